/* verification/risk_trace.txt */
# kind client(decimal) amount(hex) expected_verdict expected_accum(hex)
# every max is zero after reset, so the first orders are rejected
new_order 0 0001 rejected 0000
new_order 31 0010 rejected 0000
cancel 5 0004 cancelled 0000
new_limit 3 0064 limit_set 0000
new_order 3 0014 accepted 0014
new_order 3 001e accepted 0032
new_order 3 0031 accepted 0063
new_order 3 0001 rejected 0063
new_order 3 0005 rejected 0063
cancel 3 000a cancelled 0059
new_order 3 0005 accepted 005e
cancel 3 0100 cancelled 0000
new_order 3 0032 accepted 0032
new_order 3 0032 rejected 0032
cancel 3 0001 cancelled 0031
new_order 3 0032 accepted 0063
new_limit 7 0100 limit_set 0000
new_limit 31 ffff limit_set 0000
new_order 7 0080 accepted 0080
new_order 31 fff0 accepted fff0
new_order 7 0080 rejected 0080
new_order 31 0010 rejected fff0
new_order 31 000e accepted fffe
new_order 31 0001 rejected fffe
new_order 7 007f accepted 00ff
cancel 31 fffe cancelled 0000
new_order 31 ffff rejected 0000
new_order 31 fffe accepted fffe
new_limit 0 0002 limit_set 0000
new_order 0 0001 accepted 0001
new_order 0 0001 rejected 0001
new_order 3 0000 accepted 0063
cancel 7 00ff cancelled 0000
new_order 7 00ff accepted 00ff
new_limit 7 0010 limit_set 00ff
new_order 7 0000 rejected 00ff
cancel 7 ffff cancelled 0000
new_order 7 000f accepted 000f
new_order 3 0001 rejected 0063

/* tb.f */
+incdir+source
source/risk_pkg.sv
source/order_intake.sv
source/client_limit_store.sv
source/risk_engine.sv
source/order_egress.sv
source/risk_gate_top.sv
verification/risk_gate_props.sv
verification/risk_gate_tb.sv

/* Makefile */
SIM_TOOL  = verilator
SIM_FLAGS = --binary --timing --assert
TOP       = risk_gate_tb
FILELIST  = tb.f
OBJ_DIR   = obj_dir
SIM_BIN   = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
SOURCES   = $(shell grep -v '^+' $(FILELIST)) $(wildcard source/*.svh)

.PHONY: all run clean

all: run

# rebuilt only when a source, header or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(SIM_TOOL) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || echo "simulator returned an error status" >> $(LOG)
	@cat $(LOG)
	@if grep -q -e "TB FAILED" -e "simulator returned an error status" $(LOG); then \
	  echo "run failed, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* verification/risk_gate_tb.sv */
// risk gate testbench, trace loader, host order driver, verdict checker and watchdog
`timescale 1ns/100ps
`include "risk_params.svh"

module risk_gate_tb;

  logic                   clk;
  logic                   rst_n;
  logic                   in_req, in_ack;
  risk_pkg::order_kind_t  in_kind;
  logic [`RISK_CID_W-1:0] in_client;
  logic [`RISK_AMT_W-1:0] in_amount;
  logic                   out_req, out_ack;
  risk_pkg::verdict_t     out_verdict;
  logic [`RISK_CID_W-1:0] out_client;
  logic [`RISK_AMT_W-1:0] out_accum;
  logic                   st_check, st_send, st_update;  // engine status, counted per cycle

  // orders by trace position
  risk_pkg::order_kind_t  kind_list[$];
  logic [`RISK_CID_W-1:0] client_list[$];
  logic [`RISK_AMT_W-1:0] amount_list[$];
  // expected results, popped as verdicts arrive
  risk_pkg::verdict_t     exp_verdict_q[$];
  logic [`RISK_CID_W-1:0] exp_client_q[$];
  logic [`RISK_AMT_W-1:0] exp_accum_q[$];

  int          order_count  = 0;
  int          received     = 0;
  int          checks       = 0;
  int          errors       = 0;
  bit          trace_loaded = 1'b0;
  int unsigned lcg_state    = 32'd35037;
  int          check_cycles  = 0;  // cycles seen in check_risk
  int          send_cycles   = 0;
  int          update_cycles = 0;

  risk_gate_top dut (
    .clk, .rst_n, .in_req, .in_kind, .in_client, .in_amount, .in_ack,
    .out_req, .out_verdict, .out_client, .out_accum, .out_ack,
    .check_risk(st_check), .send_order(st_send), .update_max(st_update)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;  // 20 ns period
  end

  function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state >> 16;  // upper bits, low ones repeat quickly
  endfunction

  function automatic bit decode_kind(input string name, output risk_pkg::order_kind_t kind);
    kind = risk_pkg::new_order;
    if (name == "new_limit")
      kind = risk_pkg::new_limit;
    else if (name == "cancel")
      kind = risk_pkg::cancel;
    else if (name != "new_order")
      return 1'b0;  // unknown token
    return 1'b1;
  endfunction

  function automatic bit decode_verdict(input string name, output risk_pkg::verdict_t verdict);
    verdict = risk_pkg::accepted;
    if (name == "rejected")
      verdict = risk_pkg::rejected;
    else if (name == "limit_set")
      verdict = risk_pkg::limit_set;
    else if (name == "cancelled")
      verdict = risk_pkg::cancelled;
    else if (name != "accepted")
      return 1'b0;
    return 1'b1;
  endfunction

  // orders of one kind in the trace
  function automatic int count_kind(input risk_pkg::order_kind_t kind);
    int n;
    n = 0;
    foreach (kind_list[i])
      if (kind_list[i] == kind)
        n++;
    return n;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("mismatch in %s: expected %0h, actual %0h", name, expected, actual);
    end
  endtask

  task automatic load_trace();
    int                     fd;
    int                     n;
    int                     client_v;
    logic [`RISK_AMT_W-1:0] amount_v, accum_v;
    string                  tok, vname, rest;
    risk_pkg::order_kind_t  kind_v;
    risk_pkg::verdict_t     verdict_v;
    fd = $fopen("verification/risk_trace.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("cannot open the trace file verification/risk_trace.txt");
      return;
    end
    while ($fscanf(fd, "%s", tok) == 1) begin
      if (tok.getc(0) == "#") begin
        n = $fgets(rest, fd);  // rest of a comment line
        continue;
      end
      n = $fscanf(fd, "%d %h %s %h", client_v, amount_v, vname, accum_v);
      if (n != 4 || !decode_kind(tok, kind_v) || !decode_verdict(vname, verdict_v) ||
          client_v < 0 || client_v >= `RISK_CLIENTS) begin
        errors++;
        $display("trace entry %0d is malformed, it starts with %s", order_count + 1, tok);
        continue;
      end
      kind_list.push_back(kind_v);
      client_list.push_back(client_v[`RISK_CID_W-1:0]);
      amount_list.push_back(amount_v);
      exp_verdict_q.push_back(verdict_v);
      exp_client_q.push_back(client_v[`RISK_CID_W-1:0]);
      exp_accum_q.push_back(accum_v);
      order_count++;
    end
    $fclose(fd);
  endtask

  // one full four-phase cycle on the input link
  task automatic drive_order(input int idx);
    @(posedge clk);
    in_req    <= 1'b1;
    in_kind   <= kind_list[idx];
    in_client <= client_list[idx];
    in_amount <= amount_list[idx];
    do @(posedge clk); while (!in_ack);
    in_req <= 1'b0;
    do @(posedge clk); while (in_ack);  // both low, data free to change
  endtask

  task automatic drive_orders();
    for (int i = 0; i < order_count; i++)
      drive_order(i);
  endtask

  task automatic collect_verdicts();
    int                     delay;
    risk_pkg::verdict_t     exp_v;
    logic [`RISK_CID_W-1:0] exp_c;
    logic [`RISK_AMT_W-1:0] exp_a;
    for (int i = 0; i < order_count; i++) begin
      do @(posedge clk); while (!out_req);
      exp_v = exp_verdict_q.pop_front();
      exp_c = exp_client_q.pop_front();
      exp_a = exp_accum_q.pop_front();
      check_value($sformatf("order %0d verdict", i), 32'(exp_v), 32'(out_verdict));
      check_value($sformatf("order %0d client", i), 32'(exp_c), 32'(out_client));
      check_value($sformatf("order %0d accum", i), 32'(exp_a), 32'(out_accum));
      received++;
      delay = int'(lcg_next() % 32'd8);  // back-pressure, 0 to 7 cycles
      repeat (delay) @(posedge clk);
      out_ack <= 1'b1;
      do @(posedge clk); while (out_req);
      out_ack <= 1'b0;
    end
  endtask

  // engine status, one count per cycle high
  always @(posedge clk) begin
    if (rst_n) begin
      if (st_check)
        check_cycles++;
      if (st_send)
        send_cycles++;
      if (st_update)
        update_cycles++;
    end
  end

  // watchdog, 40 cycles per order plus margin
  initial begin
    wait (trace_loaded);
    repeat (order_count * 40 + 500) @(posedge clk);
    $display("run timed out with %0d of %0d verdicts received", received, order_count);
    $display("TB FAILED");
    $finish;
  end

  initial begin
    bit extra;
    extra     = 1'b0;
    rst_n     = 1'b0;
    in_req    = 1'b0;
    in_kind   = risk_pkg::new_order;
    in_client = '0;
    in_amount = '0;
    out_ack   = 1'b0;
    load_trace();
    if (order_count == 0) begin
      errors++;
      $display("the trace holds no orders");
    end
    trace_loaded = 1'b1;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    fork
      drive_orders();
      collect_verdicts();
    join
    // nothing may follow the last verdict
    repeat (20) begin
      @(posedge clk);
      if (out_req)
        extra = 1'b1;
    end
    if (extra) begin
      errors++;
      $display("a verdict came out after the last order of the trace");
    end
    // one check_risk cycle per order, one apply cycle per new order or new limit
    check_value("check_risk cycles", 32'(order_count), 32'(check_cycles));
    check_value("send_order cycles", 32'(count_kind(risk_pkg::new_order)), 32'(send_cycles));
    check_value("update_max cycles", 32'(count_kind(risk_pkg::new_limit)), 32'(update_cycles));
    if (dut.u_engine.u_props.fail_count != 0) begin
      errors += dut.u_engine.u_props.fail_count;
      $display("engine assertions failed %0d times", dut.u_engine.u_props.fail_count);
    end
    $display("orders %0d, checks %0d, errors %0d", order_count, checks, errors);
    if (errors == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

endmodule

/* verification/risk_gate_props.sv */
// engine assertions on state decode outputs and the verdict handshake, bound into risk_engine
`timescale 1ns/100ps

module risk_gate_props (
  input logic               clk,
  input logic               rst_n,
  input logic               check_risk,
  input logic               send_order,
  input logic               update_max,
  input logic               vd_req,
  input logic               vd_ack,
  input risk_pkg::verdict_t vd_verdict
);

  int fail_count = 0;  // failed assertion attempts, read by the testbench

  // decoded from one state register, never two at once
  a_state_onehot: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0({check_risk, send_order, update_max}))
    else begin
      fail_count++;
      $error("engine status outputs high together");
    end

  // req held until egress answers
  a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
    vd_req && !vd_ack |=> vd_req)
    else begin
      fail_count++;
      $error("vd_req dropped before vd_ack rose");
    end

  // verdict frozen for the whole request phase
  a_verdict_stable: assert property (@(posedge clk) disable iff (!rst_n)
    vd_req |=> !vd_req || $stable(vd_verdict))
    else begin
      fail_count++;
      $error("vd_verdict changed while vd_req was high");
    end

endmodule

bind risk_engine risk_gate_props u_props (
  .clk, .rst_n, .check_risk, .send_order, .update_max, .vd_req, .vd_ack, .vd_verdict
);

/* source/risk_gate_top.sv */
// risk gate top level, intake, client store, risk engine and egress
`timescale 1ns/100ps
`include "risk_params.svh"

module risk_gate_top (
  input  logic                   clk,
  input  logic                   rst_n,
  // order input link
  input  logic                   in_req,
  input  risk_pkg::order_kind_t  in_kind,
  input  logic [`RISK_CID_W-1:0] in_client,
  input  logic [`RISK_AMT_W-1:0] in_amount,
  output logic                   in_ack,
  // verdict output link
  output logic                   out_req,
  output risk_pkg::verdict_t     out_verdict,
  output logic [`RISK_CID_W-1:0] out_client,
  output logic [`RISK_AMT_W-1:0] out_accum,
  input  logic                   out_ack,
  // engine status
  output logic                   check_risk,
  output logic                   send_order,
  output logic                   update_max
);

  // intake to engine
  logic                   ord_req, ord_ack;
  risk_pkg::order_kind_t  ord_kind;
  logic [`RISK_CID_W-1:0] ord_client;
  logic [`RISK_AMT_W-1:0] ord_amount;
  // engine and store
  logic [`RISK_CID_W-1:0] rd_client, wr_client;
  logic [`RISK_AMT_W-1:0] rd_accum, rd_max, wr_accum, wr_max;
  logic                   wr_en;
  // engine to egress
  logic                   vd_req, vd_ack;
  risk_pkg::verdict_t     vd_verdict;
  logic [`RISK_CID_W-1:0] vd_client;
  logic [`RISK_AMT_W-1:0] vd_accum;

  order_intake u_intake (
    .clk, .rst_n, .in_req, .in_kind, .in_client, .in_amount, .in_ack,
    .ord_req, .ord_kind, .ord_client, .ord_amount, .ord_ack
  );

  client_limit_store u_store (
    .clk, .rst_n, .rd_client, .rd_accum, .rd_max,
    .wr_en, .wr_client, .wr_accum, .wr_max
  );

  risk_engine u_engine (
    .clk, .rst_n, .ord_req, .ord_kind, .ord_client, .ord_amount, .ord_ack,
    .rd_client, .rd_accum, .rd_max, .wr_en, .wr_client, .wr_accum, .wr_max,
    .vd_req, .vd_verdict, .vd_client, .vd_accum, .vd_ack,
    .check_risk, .send_order, .update_max
  );

  order_egress u_egress (
    .clk, .rst_n, .vd_req, .vd_verdict, .vd_client, .vd_accum, .vd_ack,
    .out_req, .out_verdict, .out_client, .out_accum, .out_ack
  );

endmodule

/* source/order_egress.sv */
// verdict egress, one-entry output buffer with four-phase links on both sides
`timescale 1ns/100ps
`include "risk_params.svh"

module order_egress (
  input  logic                   clk,
  input  logic                   rst_n,
  // from engine
  input  logic                   vd_req,
  input  risk_pkg::verdict_t     vd_verdict,
  input  logic [`RISK_CID_W-1:0] vd_client,
  input  logic [`RISK_AMT_W-1:0] vd_accum,
  output logic                   vd_ack,
  // to host
  output logic                   out_req,
  output risk_pkg::verdict_t     out_verdict,
  output logic [`RISK_CID_W-1:0] out_client,
  output logic [`RISK_AMT_W-1:0] out_accum,
  input  logic                   out_ack
);

  logic busy;  // verdict held until the host cycle closes
  logic load;

  assign load = vd_req && !vd_ack && !busy;

  // engine side handshake
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      vd_ack <= 1'b0;
    else if (load)
      vd_ack <= 1'b1;
    else if (!vd_req)
      vd_ack <= 1'b0;  // engine released
  end

  // host side handshake and buffer state
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_req <= 1'b0;
      busy    <= 1'b0;
    end else begin
      if (load)
        out_req <= 1'b1;  // same cycle as vd_ack
      else if (out_ack)
        out_req <= 1'b0;

      if (load)
        busy <= 1'b1;
      else if (busy && !out_req && !out_ack)
        busy <= 1'b0;  // host acked and released
    end
  end

  // verdict payload
  always_ff @(posedge clk) begin
    if (load) begin
      out_verdict <= vd_verdict;
      out_client  <= vd_client;
      out_accum   <= vd_accum;
    end
  end

endmodule

/* source/risk_engine.sv */
// risk engine FSM, reads a client, checks the order, writes back, hands out the verdict
`timescale 1ns/100ps
`include "risk_params.svh"

module risk_engine (
  input  logic                   clk,
  input  logic                   rst_n,
  // order from intake
  input  logic                   ord_req,
  input  risk_pkg::order_kind_t  ord_kind,
  input  logic [`RISK_CID_W-1:0] ord_client,
  input  logic [`RISK_AMT_W-1:0] ord_amount,
  output logic                   ord_ack,
  // store read
  output logic [`RISK_CID_W-1:0] rd_client,
  input  logic [`RISK_AMT_W-1:0] rd_accum,
  input  logic [`RISK_AMT_W-1:0] rd_max,
  // store write
  output logic                   wr_en,
  output logic [`RISK_CID_W-1:0] wr_client,
  output logic [`RISK_AMT_W-1:0] wr_accum,
  output logic [`RISK_AMT_W-1:0] wr_max,
  // verdict to egress
  output logic                   vd_req,
  output risk_pkg::verdict_t     vd_verdict,
  output logic [`RISK_CID_W-1:0] vd_client,
  output logic [`RISK_AMT_W-1:0] vd_accum,
  input  logic                   vd_ack,
  // state decode
  output logic                   check_risk,
  output logic                   send_order,
  output logic                   update_max
);

  risk_pkg::engine_state_t state, state_nxt;

  // latched order
  risk_pkg::order_kind_t  kind_q;
  logic [`RISK_CID_W-1:0] client_q;
  logic [`RISK_AMT_W-1:0] amount_q;

  // updated client fields and verdict, set in check_risk
  logic [`RISK_AMT_W-1:0] accum_q;
  logic [`RISK_AMT_W-1:0] max_q;
  risk_pkg::verdict_t     verdict_q;

  logic [`RISK_AMT_W:0]   sum;   // extra msb, no wrap
  logic                   pass;
  logic                   start; // order accepted from intake

  assign start = (state == risk_pkg::idle) && ord_req && !ord_ack;
  assign sum   = {1'b0, rd_accum} + {1'b0, amount_q};
  assign pass  = sum < {1'b0, rd_max};  // strictly below the max

  always_comb begin
    state_nxt = state;
    case (state)
      risk_pkg::idle:       if (start) state_nxt = risk_pkg::read;
      risk_pkg::read:       state_nxt = risk_pkg::check_risk;  // store data lands here
      risk_pkg::check_risk: begin
        case (kind_q)
          risk_pkg::new_limit: state_nxt = risk_pkg::update_max;
          risk_pkg::cancel:    state_nxt = risk_pkg::cancel_fill;
          default:             state_nxt = risk_pkg::send_order;
        endcase
      end
      risk_pkg::send_order,
      risk_pkg::update_max,
      risk_pkg::cancel_fill: state_nxt = risk_pkg::hand_out;
      // leave once req dropped and egress ack back low
      risk_pkg::hand_out:   if (!vd_req && !vd_ack) state_nxt = risk_pkg::idle;
      default:              state_nxt = risk_pkg::idle;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= risk_pkg::idle;
      ord_ack <= 1'b0;
      vd_req  <= 1'b0;
    end else begin
      state <= state_nxt;

      if (start)
        ord_ack <= 1'b1;  // together with the read
      else if (!ord_req)
        ord_ack <= 1'b0;

      // raised on entry to hand_out, dropped on egress ack
      if ((state_nxt == risk_pkg::hand_out) && (state != risk_pkg::hand_out))
        vd_req <= 1'b1;
      else if (vd_ack)
        vd_req <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      kind_q   <= ord_kind;
      client_q <= ord_client;
      amount_q <= ord_amount;
    end
    if (state == risk_pkg::check_risk) begin
      accum_q <= rd_accum;  // default, fields unchanged
      max_q   <= rd_max;
      case (kind_q)
        risk_pkg::new_limit: begin
          max_q     <= amount_q;
          verdict_q <= risk_pkg::limit_set;
        end
        risk_pkg::cancel: begin
          // saturate at zero
          accum_q   <= (amount_q > rd_accum) ? '0 : rd_accum - amount_q;
          verdict_q <= risk_pkg::cancelled;
        end
        default: begin
          if (pass) begin
            accum_q   <= sum[`RISK_AMT_W-1:0];
            verdict_q <= risk_pkg::accepted;
          end else begin
            verdict_q <= risk_pkg::rejected;
          end
        end
      endcase
    end
  end

  assign rd_client = client_q;

  // write in every apply state, a rejected order writes back the old values
  assign wr_en     = send_order || update_max || (state == risk_pkg::cancel_fill);
  assign wr_client = client_q;
  assign wr_accum  = accum_q;
  assign wr_max    = max_q;

  assign vd_verdict = verdict_q;
  assign vd_client  = client_q;
  assign vd_accum   = accum_q;

  assign check_risk = (state == risk_pkg::check_risk);
  assign send_order = (state == risk_pkg::send_order);
  assign update_max = (state == risk_pkg::update_max);

endmodule

/* source/client_limit_store.sv */
// per-client accum and max register file, registered read port, one write port
`timescale 1ns/100ps
`include "risk_params.svh"

module client_limit_store (
  input  logic                   clk,
  input  logic                   rst_n,
  // read port, data one cycle after the address
  input  logic [`RISK_CID_W-1:0] rd_client,
  output logic [`RISK_AMT_W-1:0] rd_accum,
  output logic [`RISK_AMT_W-1:0] rd_max,
  // write port
  input  logic                   wr_en,
  input  logic [`RISK_CID_W-1:0] wr_client,
  input  logic [`RISK_AMT_W-1:0] wr_accum,
  input  logic [`RISK_AMT_W-1:0] wr_max
);

  logic [`RISK_AMT_W-1:0] accum_mem [`RISK_CLIENTS];  // open amount per client
  logic [`RISK_AMT_W-1:0] max_mem   [`RISK_CLIENTS];  // trade limit per client

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `RISK_CLIENTS; i++) begin
        accum_mem[i] <= '0;
        max_mem[i]   <= '0;  // zero max, every order rejected
      end
      rd_accum <= '0;
      rd_max   <= '0;
    end else begin
      if (wr_en) begin
        accum_mem[wr_client] <= wr_accum;
        max_mem[wr_client]   <= wr_max;
      end
      // read sees the write of the same cycle
      if (wr_en && (wr_client == rd_client)) begin
        rd_accum <= wr_accum;
        rd_max   <= wr_max;
      end else begin
        rd_accum <= accum_mem[rd_client];
        rd_max   <= max_mem[rd_client];
      end
    end
  end

endmodule

/* source/order_intake.sv */
// order intake, host four-phase link in, one-entry buffer, four-phase link to engine
`timescale 1ns/100ps
`include "risk_params.svh"

module order_intake (
  input  logic                   clk,
  input  logic                   rst_n,
  // host side
  input  logic                   in_req,
  input  risk_pkg::order_kind_t  in_kind,
  input  logic [`RISK_CID_W-1:0] in_client,
  input  logic [`RISK_AMT_W-1:0] in_amount,
  output logic                   in_ack,
  // engine side
  output logic                   ord_req,
  output risk_pkg::order_kind_t  ord_kind,
  output logic [`RISK_CID_W-1:0] ord_client,
  output logic [`RISK_AMT_W-1:0] ord_amount,
  input  logic                   ord_ack
);

  logic full;  // buffer holds an order not yet released by the engine
  logic take;  // capture strobe

  // new request, previous host cycle closed, nothing pending
  assign take = in_req && !in_ack && !full;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      in_ack  <= 1'b0;
      ord_req <= 1'b0;
      full    <= 1'b0;
    end else begin
      // host handshake
      if (take)
        in_ack <= 1'b1;
      else if (!in_req)
        in_ack <= 1'b0;  // host released, close the cycle

      // engine handshake, req rises with in_ack
      if (take)
        ord_req <= 1'b1;
      else if (ord_ack)
        ord_req <= 1'b0;

      // free only once the engine ack is back low
      if (take)
        full <= 1'b1;
      else if (full && !ord_req && !ord_ack)
        full <= 1'b0;
    end
  end

  // order payload, held while full
  always_ff @(posedge clk) begin
    if (take) begin
      ord_kind   <= in_kind;
      ord_client <= in_client;
      ord_amount <= in_amount;
    end
  end

endmodule

/* source/risk_pkg.sv */
// package with order kind, verdict and engine state types
package risk_pkg;

  // kind of request coming in from the client port
  typedef enum logic [1:0] {
    new_order = 2'd0,  // trade, checked against the max
    new_limit = 2'd1,  // replaces the client max
    cancel    = 2'd2   // lowers the accumulated amount
  } order_kind_t;

  // result sent back for every order
  typedef enum logic [1:0] {
    accepted  = 2'd0,  // order passed, accum grown
    rejected  = 2'd1,  // would reach or pass the max
    limit_set = 2'd2,
    cancelled = 2'd3
  } verdict_t;

  // risk engine sequence
  typedef enum logic [2:0] {
    idle        = 3'd0,
    read        = 3'd1,  // client fields being fetched
    check_risk  = 3'd2,
    send_order  = 3'd3,
    update_max  = 3'd4,
    cancel_fill = 3'd5,
    hand_out    = 3'd6   // verdict handshake toward egress
  } engine_state_t;

endpackage

/* source/risk_params.svh */
// sizing macros for client count, client index width and amount width
`ifndef RISK_PARAMS_SVH
`define RISK_PARAMS_SVH

// client table depth
`define RISK_CLIENTS 32

// bits needed to index the client table
`define RISK_CID_W 5

// unsigned order amount, also width of the accum and max fields
`define RISK_AMT_W 16

// the risk sum is carried one bit wider than RISK_AMT_W
// so accum + amount never wraps before the compare
// RISK_CLIENTS must equal 2**RISK_CID_W, every index is a valid client

`endif
